// File: dct_row_engine.f
+incdir+.
dct_pkg.sv
sample_sequencer.sv
cosine_lane.sv
coef_serializer.sv
dct_row_engine.sv
dct_row_engine_tb.sv

// File: Bender.yml
package:
  name: dct_row_engine

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - dct_pkg.sv
      - sample_sequencer.sv
      - cosine_lane.sv
      - coef_serializer.sv
      - dct_row_engine.sv
  - target: test
    include_dirs:
      - .
    files:
      - dct_row_engine_tb.sv

// File: dct_row_engine_tb.sv
`timescale 1ns/1ns
`include "dct_settings.svh"

module dct_row_engine_tb
    import dct_pkg::*;
;

    logic       clk;
    logic       rst;
    logic [7:0] pixel;
    logic       pixel_valid;
    logic       coef_credit;
    logic       pixel_credit;
    coef_t      coef;
    logic       coef_valid;

    // Reference constants and model queues
    int         cos_tab [8][8];
    logic [7:0] row_buf [8];
    logic [7:0] pix_q [$];
    longint     exp_q [$];

    // Credit bookkeeping as seen from outside the DUT
    int in_credits;
    int out_credits;
    int owed;
    int received;
    int returned;
    int pixels_sent;

    // Traffic knobs
    int   gap_pct;
    int   credit_pct;
    logic hold_credits;

    logic [31:0] rng;
    string       test_name;
    int          checks;
    int          errors;
    int          tests_run;
    int          test_checks0;
    int          test_errors0;

    dct_row_engine DUT (
        .clk          (clk),
        .rst          (rst),
        .pixel        (pixel),
        .pixel_valid  (pixel_valid),
        .coef_credit  (coef_credit),
        .pixel_credit (pixel_credit),
        .coef         (coef),
        .coef_valid   (coef_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic check_value(input string name, input longint expected, input longint actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("MISMATCH test %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("ERROR test %s: %s", test_name, msg);
    endtask

    // Constants are c(u) * cos((2x+1)u*pi/16) scaled by 8192 where c(0) = 1/sqrt(2)
    task automatic build_cos_table();
        real v;
        int  u;
        int  x;
        for (u = 0; u < 8; u++) begin
            for (x = 0; x < 8; x++) begin
                v = $cos((2.0 * x + 1.0) * u * 3.14159265358979 / 16.0) * 8192.0;
                if (u == 0) begin
                    v = v / $sqrt(2.0);
                end
                if (v >= 0.0) begin
                    cos_tab[u][x] = $rtoi(v + 0.5);
                end else begin
                    cos_tab[u][x] = -$rtoi(-v + 0.5);
                end
            end
        end
    endtask

    // Queue the pixels of row_buf and the eight coefficients the model expects
    task automatic queue_row();
        longint acc;
        int     u;
        int     x;
        for (u = 0; u < `DCT_N; u++) begin
            acc = 0;
            for (x = 0; x < `DCT_N; x++) begin
                acc += (longint'(row_buf[x]) - `DCT_LEVEL_SHIFT) * cos_tab[u][x];
            end
            exp_q.push_back((acc + 4096) >>> 13);
        end
        for (x = 0; x < `DCT_N; x++) begin
            pix_q.push_back(row_buf[x]);
        end
    endtask

    task automatic queue_const_row(input logic [7:0] value);
        int x;
        for (x = 0; x < `DCT_N; x++) begin
            row_buf[x] = value;
        end
        queue_row();
    endtask

    task automatic queue_random_rows(input int count);
        logic [31:0] r;
        int          n;
        int          x;
        for (n = 0; n < count; n++) begin
            for (x = 0; x < `DCT_N; x++) begin
                r = next_rand();
                row_buf[x] = r[7:0];
            end
            queue_row();
        end
    endtask

    // ------------------------------------------------------------
    // Per-cycle monitor and driver at the falling edge
    // ------------------------------------------------------------
    task automatic sample_outputs();
        if (pixel_credit) begin
            in_credits++;
            if (in_credits > `DCT_N) begin
                report_failure("pixel_credit raised the held input credits above 8");
            end
        end
        if (coef_valid) begin
            if (out_credits == 0) begin
                report_failure("coef_valid was raised while the engine held no output credit");
            end else begin
                out_credits--;
            end
            received++;
            owed++;
            if (received - returned > `DCT_OUT_CREDITS) begin
                report_failure("more coefficients arrived than were paid for by credits");
            end
            if (exp_q.size() == 0) begin
                report_failure("a coefficient arrived when none was expected");
            end else begin
                check_value(test_name, exp_q.pop_front(), longint'(coef));
            end
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        r = next_rand();
        if (pix_q.size() != 0 && in_credits > 0 && (r % 100) >= gap_pct) begin
            pixel       = pix_q.pop_front();
            pixel_valid = 1'b1;
            in_credits--;
            pixels_sent++;
        end else begin
            pixel       = r[23:16];
            pixel_valid = 1'b0;
        end
        r = next_rand();
        if (!hold_credits && owed > 0 && (r % 100) < credit_pct) begin
            coef_credit = 1'b1;
            owed--;
            returned++;
            out_credits++;
        end else begin
            coef_credit = 1'b0;
        end
    endtask

    task automatic tick();
        @(negedge clk);
        sample_outputs();
        drive_inputs();
    endtask

    task automatic reset_dut();
        int n;
        @(negedge clk);
        rst         = 1'b1;
        pixel_valid = 1'b0;
        coef_credit = 1'b0;
        for (n = 0; n < 10; n++) begin
            @(negedge clk);
        end
        check_value(test_name, 0, coef_valid);
        check_value(test_name, 0, pixel_credit);
        rst = 1'b0;
        pix_q.delete();
        exp_q.delete();
        in_credits   = `DCT_N;
        out_credits  = `DCT_OUT_CREDITS;
        owed         = 0;
        received     = 0;
        returned     = 0;
        pixels_sent  = 0;
        hold_credits = 1'b0;
    endtask

    task automatic drain(input int limit);
        int    n;
        string msg;
        n = 0;
        while ((pix_q.size() != 0 || exp_q.size() != 0) && n < limit) begin
            tick();
            n++;
        end
        if (pix_q.size() != 0 || exp_q.size() != 0) begin
            msg = $sformatf("timed out with %0d pixels unsent and %0d coefficients missing",
                            pix_q.size(), exp_q.size());
            report_failure(msg);
        end
    endtask

    task automatic begin_test(input string name, input int gap, input int credit);
        test_name    = name;
        gap_pct      = gap;
        credit_pct   = credit;
        test_checks0 = checks;
        test_errors0 = errors;
        reset_dut();
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %s: %0d checks, %0d errors", test_name,
                 checks - test_checks0, errors - test_errors0);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        int n;
        rst         = 1'b1;
        pixel       = '0;
        pixel_valid = 1'b0;
        coef_credit = 1'b0;
        rng         = 32'hd416;
        checks      = 0;
        errors      = 0;
        tests_run   = 0;
        build_cos_table();

        begin_test("constant_rows", 20, 50);
        queue_const_row(8'd128);
        queue_const_row(8'd255);
        queue_const_row(8'd0);
        drain(5000);
        end_test();

        begin_test("random_rows", 30, 40);
        queue_random_rows(200);
        drain(200000);
        end_test();

        // Output credits held back while the source keeps offering rows
        begin_test("output_backpressure", 10, 60);
        queue_random_rows(6);
        hold_credits = 1'b1;
        for (n = 0; n < 400; n++) begin
            tick();
        end
        hold_credits = 1'b0;
        drain(20000);
        end_test();

        begin_test("input_credits", 0, 100);
        queue_random_rows(20);
        drain(20000);
        end_test();

        begin_test("reset_mid_stream", 30, 40);
        queue_random_rows(4);
        n = 0;
        while (pixels_sent < 2 * `DCT_N + 3 && n < 5000) begin
            tick();
            n++;
        end
        if (pixels_sent < 2 * `DCT_N + 3) begin
            report_failure("timed out before the third row was partly sent");
        end
        reset_dut();
        queue_random_rows(3);
        drain(20000);
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: dct_row_engine.sv
`timescale 1ns/1ns
`include "dct_settings.svh"

module dct_row_engine
    import dct_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`DCT_PIXEL_W-1:0] pixel,
    input  logic                    pixel_valid,
    input  logic                    coef_credit,
    output logic                    pixel_credit,
    output coef_t                   coef,
    output logic                    coef_valid
);

    sample_t sample;
    idx_t    sample_idx;
    logic    sample_valid;
    logic    row_push;
    logic    buffer_free;
    acc_t    sums [`DCT_N];

    // ------------------------------------------------------------
    // Level shift, column tagging and input credits
    // ------------------------------------------------------------
    sample_sequencer u_sequencer (
        .clk          (clk),
        .rst          (rst),
        .pixel        (pixel),
        .pixel_valid  (pixel_valid),
        .buffer_free  (buffer_free),
        .sample       (sample),
        .sample_idx   (sample_idx),
        .sample_valid (sample_valid),
        .row_push     (row_push),
        .pixel_credit (pixel_credit)
    );

    // Each frequency term has its own lane and every lane sees the same samples
    for (genvar i = 0; i < `DCT_N; i++) begin : lanes
        cosine_lane #(
            .u (i)
        ) u_lane (
            .clk          (clk),
            .rst          (rst),
            .sample       (sample),
            .sample_idx   (sample_idx),
            .sample_valid (sample_valid),
            .sum          (sums[i])
        );
    end

    // ------------------------------------------------------------
    // Rounding and coefficient output
    // ------------------------------------------------------------
    coef_serializer u_serializer (
        .clk         (clk),
        .rst         (rst),
        .sums        (sums),
        .row_push    (row_push),
        .coef_credit (coef_credit),
        .coef        (coef),
        .coef_valid  (coef_valid),
        .buffer_free (buffer_free)
    );

endmodule

// File: coef_serializer.sv
`timescale 1ns/1ns
`include "dct_settings.svh"

module coef_serializer
    import dct_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  acc_t  sums [`DCT_N],
    input  logic  row_push,
    input  logic  coef_credit,
    output coef_t coef,
    output logic  coef_valid,
    output logic  buffer_free
);

    localparam int   CRED_W   = $clog2(`DCT_OUT_CREDITS + 1);
    localparam idx_t LAST_IDX = idx_t'(`DCT_N - 1);

    acc_t              held [`DCT_N];
    acc_t              rounded;
    logic              busy;
    idx_t              send_idx;
    logic [CRED_W-1:0] credits;

    // ------------------------------------------------------------
    // Row capture
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (row_push) begin
            held <= sums;
        end
    end

    // Round half up at the binary point, then drop the fraction bits
    assign rounded = held[send_idx] + acc_t'(1 << (`DCT_FRAC - 1));
    assign coef    = coef_t'(rounded >>> `DCT_FRAC);

    assign coef_valid  = busy && (credits != '0);
    assign buffer_free = !busy;

    // ------------------------------------------------------------
    // Send sequencing
    // ------------------------------------------------------------
    // A new row is only pushed while the buffer is free
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            send_idx <= '0;
        end else if (row_push) begin
            busy     <= 1'b1;
            send_idx <= '0;
        end else if (coef_valid) begin
            send_idx <= send_idx + 1'b1;
            if (send_idx == LAST_IDX) begin
                busy <= 1'b0;
            end
        end
    end

    // Output credits are spent one per valid cycle and refilled by the consumer
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CRED_W'(`DCT_OUT_CREDITS);
        end else begin
            case ({coef_valid, coef_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// File: cosine_lane.sv
`timescale 1ns/1ns

module cosine_lane
    import dct_pkg::*;
#(
    parameter int u = 0
) (
    input  logic    clk,
    input  logic    rst,
    input  sample_t sample,
    input  idx_t    sample_idx,
    input  logic    sample_valid,
    output acc_t    sum
);

    cos_t coef_x;
    acc_t product;

    // Constant for this lane's frequency at the current column
    assign coef_x  = dct_coef(idx_t'(u), sample_idx);
    assign product = acc_t'(sample) * acc_t'(coef_x);

    // ------------------------------------------------------------
    // Row accumulator
    // ------------------------------------------------------------
    // Column 0 starts a fresh row, so no separate clear is needed between rows
    always_ff @(posedge clk) begin
        if (rst) begin
            sum <= '0;
        end else if (sample_valid) begin
            if (sample_idx == '0) begin
                sum <= product;
            end else begin
                sum <= sum + product;
            end
        end
    end

endmodule

// File: sample_sequencer.sv
`timescale 1ns/1ns
`include "dct_settings.svh"

module sample_sequencer
    import dct_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`DCT_PIXEL_W-1:0] pixel,
    input  logic                    pixel_valid,
    input  logic                    buffer_free,
    output sample_t                 sample,
    output idx_t                    sample_idx,
    output logic                    sample_valid,
    output logic                    row_push,
    output logic                    pixel_credit
);

    localparam int   CNT_W    = $clog2(`DCT_N + 1);
    localparam idx_t LAST_COL = idx_t'(`DCT_N - 1);

    idx_t             col;
    logic             row_done;
    logic [CNT_W-1:0] credit_cnt;

    // ------------------------------------------------------------
    // Input stage
    // ------------------------------------------------------------
    // The source only sends under credit, so every offered pixel is taken
    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            sample     <= sample_t'({1'b0, pixel}) - sample_t'(`DCT_LEVEL_SHIFT);
            sample_idx <= col;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_valid <= 1'b0;
            col          <= '0;
        end else begin
            sample_valid <= pixel_valid;
            if (pixel_valid) begin
                col <= col + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Row hand-off and credit return
    // ------------------------------------------------------------
    // Set once the lanes have summed the last column of the row
    always_ff @(posedge clk) begin
        if (rst) begin
            row_done <= 1'b0;
        end else if (row_push) begin
            row_done <= 1'b0;
        end else if (sample_valid && sample_idx == LAST_COL) begin
            row_done <= 1'b1;
        end
    end

    assign row_push = row_done && buffer_free;

    // Credits come back only after the capture, so the next row cannot
    // overwrite the lane sums before the serializer has them
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= '0;
        end else if (row_push) begin
            credit_cnt <= CNT_W'(`DCT_N);
        end else if (credit_cnt != '0) begin
            credit_cnt <= credit_cnt - 1'b1;
        end
    end

    assign pixel_credit = (credit_cnt != '0);

endmodule

// File: dct_pkg.sv
`include "dct_settings.svh"

package dct_pkg;

    typedef logic signed [8:0]               sample_t;
    typedef logic        [2:0]               idx_t;
    typedef logic signed [`DCT_CONST_W-1:0]  cos_t;
    typedef logic signed [`DCT_ACC_W-1:0]    acc_t;
    typedef logic signed [`DCT_OUT_W-1:0]    coef_t;

    // ------------------------------------------------------------
    // Cosine constant for frequency u at column x
    // ------------------------------------------------------------
    // Values are cos scaled by 8192, with the 1/sqrt(2) weight folded into u = 0.
    // The angle (2x+1)u*pi/16 is tracked in units of pi/16 and folded into the
    // first quadrant, so only seven magnitudes are needed
    function automatic cos_t dct_coef(input idx_t u, input idx_t x);
        int   k;
        logic neg;
        cos_t mag;
        if (u == '0) begin
            return cos_t'(5793);
        end
        k = ((2 * int'(x) + 1) * int'(u)) % 32;
        if (k > 16) begin
            k = 32 - k;
        end
        // Second quadrant gives a negative cosine
        neg = (k > 8);
        if (neg) begin
            k = 16 - k;
        end
        case (k)
            1:       mag = cos_t'(8035);
            2:       mag = cos_t'(7568);
            3:       mag = cos_t'(6811);
            4:       mag = cos_t'(5793);
            5:       mag = cos_t'(4551);
            6:       mag = cos_t'(3135);
            7:       mag = cos_t'(1598);
            default: mag = '0;
        endcase
        return neg ? -mag : mag;
    endfunction

endpackage

// File: dct_settings.svh
`ifndef DCT_SETTINGS_SVH
`define DCT_SETTINGS_SVH

// Samples per row, which is also the number of frequency lanes
`define DCT_N           8
`define DCT_PIXEL_W     8
`define DCT_LEVEL_SHIFT 128

// Fixed-point format of the cosine constants and the lane accumulators
`define DCT_CONST_W     14
`define DCT_FRAC        13
`define DCT_ACC_W       26

// Coefficient output
`define DCT_OUT_W       11
`define DCT_OUT_CREDITS 4

`endif
